/* build.f */
+incdir+dv
common/merge_data_pkg.sv
design/merge_fifo.sv
merge_config/merge_config_capture.sv
merge_generator/merge_generator.sv
design/engine_merge_data.sv
dv/tb_engine_merge_data.sv

/* common/merge_data_pkg.sv */
// Merge engine shared sizes, packet types and configuration word decoding
package merge_data_pkg;

    // ------------------------------------------------
    // Sizes
    // ------------------------------------------------
    localparam int unsigned NUM_LANES   = 4;
    localparam int unsigned DATA_W      = 32;
    localparam int unsigned ADDR_W      = 16;
    localparam int unsigned COUNT_W     = 16;
    localparam int unsigned FIFO_DEPTH  = 16;
    // Headroom for packets already in flight when prog_full rises
    localparam int unsigned PROG_THRESH = 12;
    localparam int unsigned FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    // ------------------------------------------------
    // Configuration encodings
    // ------------------------------------------------
    localparam logic [ADDR_W-1:0] CONFIG_ADDR_MODE = 0;
    localparam logic [ADDR_W-1:0] CONFIG_ADDR_BIAS = 1;

    localparam logic OP_ADD = 1'b0;
    localparam logic OP_MAX = 1'b1;

    // ------------------------------------------------
    // Packet and configuration types
    // ------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } memory_packet_payload_t;

    typedef struct packed {
        logic                   valid;
        memory_packet_payload_t payload;
    } memory_packet_t;

    // Mode word at address 0, lane mask in the low bits
    typedef struct packed {
        logic [COUNT_W-1:0]                    count;
        logic [DATA_W-COUNT_W-1-NUM_LANES-1:0] reserved;
        logic                                  op;
        logic [NUM_LANES-1:0]                  lane_mask;
    } merge_mode_t;

    // One memory data word, read by address as mode or as bias
    typedef union packed {
        merge_mode_t       mode;
        logic [DATA_W-1:0] bias;
    } config_word_u;

    typedef struct packed {
        logic              valid;
        merge_mode_t       mode;
        logic [DATA_W-1:0] bias;
    } merge_config_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic valid;
        logic prog_full;
    } fifo_status_t;

endpackage

/* design/engine_merge_data.sv */
// Merge engine top, registered ports around lane, memory and output FIFOs
`timescale 1ns/10ps

module engine_merge_data (
    input  logic                                 ap_clk,
    input  logic                                 areset,
    input  merge_data_pkg::memory_packet_t       response_engine_in [merge_data_pkg::NUM_LANES],
    output logic [merge_data_pkg::NUM_LANES-1:0] response_engine_prog_full,
    input  merge_data_pkg::memory_packet_t       response_memory_in,
    output logic                                 response_memory_prog_full,
    output merge_data_pkg::memory_packet_t       request_engine_out,
    input  logic                                 request_ready,
    output logic                                 done_out
);

    logic areset_csr_engine;

    merge_data_pkg::memory_packet_t response_engine_in_reg [merge_data_pkg::NUM_LANES];
    merge_data_pkg::memory_packet_t response_memory_in_reg;

    merge_data_pkg::fifo_status_t           lane_status [merge_data_pkg::NUM_LANES];
    merge_data_pkg::memory_packet_payload_t lane_dout [merge_data_pkg::NUM_LANES];
    logic [merge_data_pkg::NUM_LANES-1:0]   lane_pop;
    logic [merge_data_pkg::NUM_LANES-1:0]   lane_empty;
    logic [merge_data_pkg::NUM_LANES-1:0]   lane_prog_full;

    merge_data_pkg::fifo_status_t           mem_status;
    merge_data_pkg::memory_packet_payload_t mem_dout;
    logic                                   mem_pop;

    merge_data_pkg::fifo_status_t           out_status;
    merge_data_pkg::memory_packet_payload_t out_dout;
    logic                                   out_pop;

    merge_data_pkg::merge_config_t          merge_config;
    merge_data_pkg::memory_packet_payload_t merged_data;
    logic                                   merged_push;
    logic                                   config_release;
    logic                                   emitted_all;
    logic                                   all_empty;

    always_ff @(posedge ap_clk) begin
        areset_csr_engine <= areset;
    end

    // ------------------------------------------------
    // Input registers
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            for (int i = 0; i < merge_data_pkg::NUM_LANES; i++) begin
                response_engine_in_reg[i].valid <= 1'b0;
            end
            response_memory_in_reg.valid <= 1'b0;
        end else begin
            for (int i = 0; i < merge_data_pkg::NUM_LANES; i++) begin
                response_engine_in_reg[i].valid <= response_engine_in[i].valid;
            end
            response_memory_in_reg.valid <= response_memory_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < merge_data_pkg::NUM_LANES; i++) begin
            response_engine_in_reg[i].payload <= response_engine_in[i].payload;
        end
        response_memory_in_reg.payload <= response_memory_in.payload;
    end

    // ------------------------------------------------
    // FIFOs
    // ------------------------------------------------
    for (genvar i = 0; i < merge_data_pkg::NUM_LANES; i++) begin : g_lane_fifo
        merge_fifo u_lane_fifo (
            .ap_clk            (ap_clk),
            .areset_csr_engine (areset_csr_engine),
            .push              (response_engine_in_reg[i].valid),
            .din               (response_engine_in_reg[i].payload),
            .pop               (lane_pop[i]),
            .dout              (lane_dout[i]),
            .status            (lane_status[i])
        );
        assign lane_empty[i]     = lane_status[i].empty;
        assign lane_prog_full[i] = lane_status[i].prog_full;
    end

    merge_fifo u_memory_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .push              (response_memory_in_reg.valid),
        .din               (response_memory_in_reg.payload),
        .pop               (mem_pop),
        .dout              (mem_dout),
        .status            (mem_status)
    );

    // Consumer stalls by dropping request_ready
    assign out_pop = request_ready & ~out_status.empty;

    merge_fifo u_output_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .push              (merged_push),
        .din               (merged_data),
        .pop               (out_pop),
        .dout              (out_dout),
        .status            (out_status)
    );

    merge_config_capture u_merge_config_capture (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .mem_status        (mem_status),
        .mem_data          (mem_dout),
        .mem_pop           (mem_pop),
        .config_release    (config_release),
        .merge_config      (merge_config)
    );

    merge_generator u_merge_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .merge_config      (merge_config),
        .lane_status       (lane_status),
        .lane_data         (lane_dout),
        .lane_pop          (lane_pop),
        .out_prog_full     (out_status.prog_full),
        .merged_push       (merged_push),
        .merged_data       (merged_data),
        .emitted_all       (emitted_all),
        .config_release    (config_release)
    );

    // ------------------------------------------------
    // Output registers and done
    // ------------------------------------------------
    assign all_empty = (&lane_empty) & mem_status.empty & out_status.empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_engine_out.valid  <= 1'b0;
            response_engine_prog_full <= '0;
            response_memory_prog_full <= 1'b0;
            done_out                  <= 1'b0;
        end else begin
            request_engine_out.valid  <= out_status.valid;
            response_engine_prog_full <= lane_prog_full;
            response_memory_prog_full <= mem_status.prog_full;
            // Wait for the last read beat to clear before done
            done_out                  <= emitted_all & all_empty & ~out_status.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= out_dout;
    end

endmodule

/* design/merge_fifo.sv */
// Synchronous packet payload FIFO with registered read data and fill status flags
`timescale 1ns/10ps

module merge_fifo (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_engine,
    input  logic                                   push,
    input  merge_data_pkg::memory_packet_payload_t din,
    input  logic                                   pop,
    output merge_data_pkg::memory_packet_payload_t dout,
    output merge_data_pkg::fifo_status_t           status
);

    merge_data_pkg::memory_packet_payload_t mem [merge_data_pkg::FIFO_DEPTH];

    logic [merge_data_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [merge_data_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [merge_data_pkg::FIFO_CNT_W-1:0] occupancy;
    logic                                  rd_valid;
    logic                                  push_ok;
    logic                                  pop_ok;

    // Full drops the push, empty ignores the pop
    assign push_ok = push & ~status.full;
    assign pop_ok  = pop & ~status.empty;

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= pop_ok;
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // ------------------------------------------------
    // Storage and read register
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
        if (pop_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // Flags follow the registered occupancy
    assign status.empty     = (occupancy == '0);
    assign status.full      = (occupancy == merge_data_pkg::FIFO_DEPTH);
    assign status.prog_full = (occupancy >= merge_data_pkg::PROG_THRESH);
    assign status.valid     = rd_valid;

endmodule

/* dv/merge_vectors.svh */
// Merge engine test vectors, one row per test case with mode, bias and lane stimulus
`ifndef MERGE_VECTORS_SVH
`define MERGE_VECTORS_SVH

localparam int NUM_VECTORS  = 5;
localparam int STALL_CYCLES = 30;

// Mode word layout is count[31:16], op[4], lane_mask[3:0]
// Seeds are XORed into the random lane words, lane 3 in the top 32 bits
string       vec_name      [NUM_VECTORS];
logic [31:0] vec_mode      [NUM_VECTORS];
logic [31:0] vec_bias      [NUM_VECTORS];
logic [31:0] vec_lane_seed [NUM_VECTORS][merge_data_pkg::NUM_LANES];
logic        vec_stall     [NUM_VECTORS];
int          vec_late_lane [NUM_VECTORS];
int          vec_late_wait [NUM_VECTORS];

task automatic set_vector(input int r, input string name, input logic [31:0] mode,
                          input logic [31:0] bias,
                          input logic [merge_data_pkg::NUM_LANES*32-1:0] seeds,
                          input logic stall, input int late_lane, input int late_wait);
    begin
        vec_name[r]      = name;
        vec_mode[r]      = mode;
        vec_bias[r]      = bias;
        vec_stall[r]     = stall;
        vec_late_lane[r] = late_lane;
        vec_late_wait[r] = late_wait;
        for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
            vec_lane_seed[r][l] = seeds[l*32 +: 32];
        end
    end
endtask

task automatic load_vector_table();
    begin
        set_vector(0, "add_all_lanes", 32'h0010_000F, 32'h0000_1234,
                   {32'h1357_9BDF, 32'h00FF_00FF, 32'h0F0F_0000, 32'h0000_0000}, 1'b0, 0, 0);
        set_vector(1, "max_lanes_0_2", 32'h000C_0015, 32'h8000_0000,
                   {32'h0000_0000, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000}, 1'b0, 0, 0);
        set_vector(2, "add_late_lane", 32'h000A_000F, 32'h0000_0007,
                   {32'h2468_ACE0, 32'h0000_0000, 32'hFFFF_0000, 32'h0000_FFFF}, 1'b0, 2, 25);
        set_vector(3, "max_ready_stall", 32'h0018_001B, 32'h4000_0000,
                   {32'h0000_0000, 32'h0000_0000, 32'h5A5A_5A5A, 32'h0000_0000}, 1'b1, 0, 0);
        // Bias close to the top so sums wrap
        set_vector(4, "add_single_lane", 32'h0006_0008, 32'hFFFF_FFF0,
                   {32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}, 1'b0, 0, 0);
    end
endtask

`endif

/* dv/tb_engine_merge_data.sv */
// Table-driven testbench for the merge engine with checked merged output
`timescale 1ns/10ps

module tb_engine_merge_data;

    localparam int MAX_COUNT = 64;
    localparam int DONE_WAIT = 30;

    logic                                 ap_clk;
    logic                                 areset;
    merge_data_pkg::memory_packet_t       response_engine_in [merge_data_pkg::NUM_LANES];
    logic [merge_data_pkg::NUM_LANES-1:0] response_engine_prog_full;
    merge_data_pkg::memory_packet_t       response_memory_in;
    logic                                 response_memory_prog_full;
    merge_data_pkg::memory_packet_t       request_engine_out;
    logic                                 request_ready;
    logic                                 done_out;

    logic [31:0] lane_words [merge_data_pkg::NUM_LANES][MAX_COUNT];
    integer      seed;
    int          checks;
    int          errors;
    int          watchdog_limit;

    `include "merge_vectors.svh"

    engine_merge_data u_engine_merge_data (
        .ap_clk                    (ap_clk),
        .areset                    (areset),
        .response_engine_in        (response_engine_in),
        .response_engine_prog_full (response_engine_prog_full),
        .response_memory_in        (response_memory_in),
        .response_memory_prog_full (response_memory_prog_full),
        .request_engine_out        (request_engine_out),
        .request_ready             (request_ready),
        .done_out                  (done_out)
    );

    always begin
        ap_clk = 1'b0;
        #5;
        ap_clk = 1'b1;
        #5;
    end

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    task automatic clear_inputs();
        begin
            for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
                response_engine_in[l] = '0;
            end
            response_memory_in = '0;
        end
    endtask

    task automatic compare_word(input string test_name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        begin
            checks++;
            assert (actual === expected)
            else begin
                errors++;
                $display("CHECK FAILED %s %s: expected %h, actual %h",
                         test_name, what, expected, actual);
            end
        end
    endtask

    // Both prog_full outputs stay low while every FIFO is drained
    task automatic check_prog_full_low(input string test_name);
        begin
            compare_word(test_name, "response_engine_prog_full", 32'd0,
                         32'(response_engine_prog_full));
            compare_word(test_name, "response_memory_prog_full", 32'd0,
                         32'(response_memory_prog_full));
        end
    endtask

    // Sum or unsigned max of the enabled lane words and the bias
    function automatic logic [31:0] expected_result(input logic op, input logic [3:0] mask,
                                                    input logic [31:0] bias, input int k);
        logic [31:0] sum;
        logic [31:0] top;
        begin
            sum = bias;
            top = bias;
            for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
                if (mask[l]) begin
                    sum = sum + lane_words[l][k];
                    if (lane_words[l][k] > top) begin
                        top = lane_words[l][k];
                    end
                end
            end
            return (op == merge_data_pkg::OP_MAX) ? top : sum;
        end
    endfunction

    function automatic int watchdog_cycles();
        merge_data_pkg::merge_mode_t mode;
        int                          total;
        begin
            total = 10;
            for (int r = 0; r < NUM_VECTORS; r++) begin
                mode  = vec_mode[r];
                total = total + int'(mode.count) + 40 + vec_late_wait[r];
                if (vec_stall[r]) begin
                    total = total + STALL_CYCLES;
                end
            end
            return total;
        end
    endfunction

    task automatic send_config(input logic [31:0] mode_word, input logic [31:0] bias_word);
        begin
            @(negedge ap_clk);
            response_memory_in.valid           = 1'b1;
            response_memory_in.payload.address = merge_data_pkg::CONFIG_ADDR_MODE;
            response_memory_in.payload.data    = mode_word;
            @(negedge ap_clk);
            response_memory_in.payload.address = merge_data_pkg::CONFIG_ADDR_BIAS;
            response_memory_in.payload.data    = bias_word;
            @(negedge ap_clk);
            response_memory_in = '0;
        end
    endtask

    // ------------------------------------------------
    // One table row
    // ------------------------------------------------
    task automatic run_vector(input int r);
        merge_data_pkg::merge_mode_t mode;
        int   count;
        int   sent [merge_data_pkg::NUM_LANES];
        int   received;
        int   cycle;
        int   stall_left;
        int   stall_hits;
        int   extra;
        int   errors_before;
        bit   stall_used;
        bit   done_early;
        bit   done_seen;
        bit   late;
        logic ready_d1;
        logic ready_d2;
        begin
            mode          = vec_mode[r];
            count         = int'(mode.count);
            errors_before = errors;
            received      = 0;
            cycle         = 0;
            stall_left    = 0;
            stall_hits    = 0;
            extra         = 0;
            stall_used    = 1'b0;
            done_early    = 1'b0;
            done_seen     = 1'b0;
            ready_d1      = 1'b1;
            ready_d2      = 1'b1;
            for (int k = 0; k < count; k++) begin
                for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
                    lane_words[l][k] = $random(seed) ^ vec_lane_seed[r][l];
                end
            end
            for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
                sent[l] = 0;
            end

            send_config(vec_mode[r], vec_bias[r]);
            repeat (8) @(negedge ap_clk);
            compare_word(vec_name[r], "done_out after mode word", 32'd0, {31'd0, done_out});

            while (received < count) begin
                @(negedge ap_clk);
                // Valid now reflects the ready level from two edges back
                if (!ready_d2 && request_engine_out.valid) begin
                    stall_hits++;
                end
                if (done_out) begin
                    done_early = 1'b1;
                end
                if (request_engine_out.valid) begin
                    compare_word(vec_name[r], $sformatf("data[%0d]", received),
                                 expected_result(mode.op, mode.lane_mask, vec_bias[r], received),
                                 request_engine_out.payload.data);
                    compare_word(vec_name[r], $sformatf("address[%0d]", received),
                                 received, {16'd0, request_engine_out.payload.address});
                    received++;
                end

                for (int l = 0; l < merge_data_pkg::NUM_LANES; l++) begin
                    late = (l == vec_late_lane[r]) && (cycle < vec_late_wait[r]);
                    response_engine_in[l] = '0;
                    if (mode.lane_mask[l] && sent[l] < count && !late
                        && !response_engine_prog_full[l]) begin
                        response_engine_in[l].valid           = 1'b1;
                        response_engine_in[l].payload.address = sent[l];
                        response_engine_in[l].payload.data    = lane_words[l][sent[l]];
                        sent[l]++;
                    end
                end

                // Consumer stall once a few results are out
                if (vec_stall[r] && !stall_used && received >= 8) begin
                    stall_used = 1'b1;
                    stall_left = STALL_CYCLES;
                end
                if (stall_left > 0) begin
                    request_ready = 1'b0;
                    stall_left--;
                end else begin
                    request_ready = 1'b1;
                end
                ready_d2 = ready_d1;
                ready_d1 = request_ready;
                cycle++;
            end

            clear_inputs();
            request_ready = 1'b1;
            for (int i = 0; i < DONE_WAIT && !done_seen; i++) begin
                @(negedge ap_clk);
                if (request_engine_out.valid) begin
                    extra++;
                end
                done_seen = done_out;
            end

            compare_word(vec_name[r], "outputs while stalled", 32'd0, stall_hits);
            compare_word(vec_name[r], "done_out during run", 32'd0, {31'd0, done_early});
            compare_word(vec_name[r], "extra outputs", 32'd0, extra);
            check_prog_full_low(vec_name[r]);
            checks++;
            assert (done_seen)
            else begin
                errors++;
                $display("ERROR %s: done_out did not rise after the last output", vec_name[r]);
            end
            $display("test %0d %s: %0d of %0d outputs, %0d errors",
                     r, vec_name[r], received, count, errors - errors_before);
        end
    endtask

    // ------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------
    initial begin
        seed          = 89504;
        checks        = 0;
        errors        = 0;
        areset        = 1'b1;
        request_ready = 1'b1;
        clear_inputs();
        load_vector_table();
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset = 1'b0;
        repeat (4) @(negedge ap_clk);
        // Outputs quiet once reset is released
        compare_word("reset", "request_engine_out.valid", 32'd0,
                     32'(request_engine_out.valid));
        compare_word("reset", "done_out", 32'd0, 32'(done_out));
        check_prog_full_low("reset");
        for (int r = 0; r < NUM_VECTORS; r++) begin
            run_vector(r);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", NUM_VECTORS, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #1;
        watchdog_limit = watchdog_cycles();
        repeat (watchdog_limit) @(posedge ap_clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 watchdog_limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* merge_config/merge_config_capture.sv */
// Merge configuration capture, decodes mode and bias words from the memory response FIFO
`timescale 1ns/10ps

module merge_config_capture (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_engine,
    input  merge_data_pkg::fifo_status_t           mem_status,
    input  merge_data_pkg::memory_packet_payload_t mem_data,
    output logic                                   mem_pop,
    input  logic                                   config_release,
    output merge_data_pkg::merge_config_t          merge_config
);

    merge_data_pkg::config_word_u mem_word;
    merge_data_pkg::merge_mode_t  mode_reg;
    logic [merge_data_pkg::DATA_W-1:0] bias_reg;

    logic mode_held;
    logic bias_held;
    logic mode_hit;
    logic bias_hit;

    // Drain memory words as soon as they land
    assign mem_pop = ~mem_status.empty;

    assign mem_word = mem_data.data;
    assign mode_hit = mem_status.valid & (mem_data.address == merge_data_pkg::CONFIG_ADDR_MODE);
    assign bias_hit = mem_status.valid & (mem_data.address == merge_data_pkg::CONFIG_ADDR_BIAS);

    // ------------------------------------------------
    // Run state
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            mode_held <= 1'b0;
            bias_held <= 1'b0;
        end else begin
            if (config_release) begin
                mode_held <= 1'b0;
                bias_held <= 1'b0;
            end
            // A mode word opens a new run and forgets the old bias
            if (mode_hit) begin
                mode_held <= 1'b1;
                bias_held <= 1'b0;
            end else if (bias_hit) begin
                bias_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (mode_hit) begin
            mode_reg <= mem_word.mode;
        end
        if (bias_hit) begin
            bias_reg <= mem_word.bias;
        end
    end

    assign merge_config.valid = mode_held & bias_held;
    assign merge_config.mode  = mode_reg;
    assign merge_config.bias  = bias_reg;

endmodule

/* merge_generator/merge_generator.sv */
// Merge generator, pops enabled lanes as a group and combines their words with the bias
`timescale 1ns/10ps

module merge_generator (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_engine,
    input  merge_data_pkg::merge_config_t          merge_config,
    input  merge_data_pkg::fifo_status_t           lane_status [merge_data_pkg::NUM_LANES],
    input  merge_data_pkg::memory_packet_payload_t lane_data [merge_data_pkg::NUM_LANES],
    output logic [merge_data_pkg::NUM_LANES-1:0]   lane_pop,
    input  logic                                   out_prog_full,
    output logic                                   merged_push,
    output merge_data_pkg::memory_packet_payload_t merged_data,
    output logic                                   emitted_all,
    output logic                                   config_release
);

    logic [merge_data_pkg::NUM_LANES-1:0] lane_ready;
    logic [merge_data_pkg::COUNT_W-1:0]   issued_cnt;
    logic [merge_data_pkg::COUNT_W-1:0]   pushed_cnt;
    logic [merge_data_pkg::DATA_W-1:0]    combined;
    logic [merge_data_pkg::DATA_W-1:0]    result_data;

    logic run_active;
    logic run_start;
    logic group_issue;
    logic group_valid_d1;
    logic result_valid;
    logic last_push;

    // ------------------------------------------------
    // Group issue
    // ------------------------------------------------
    // Disabled lanes never hold back a group
    always_comb begin
        for (int i = 0; i < merge_data_pkg::NUM_LANES; i++) begin
            lane_ready[i] = ~lane_status[i].empty | ~merge_config.mode.lane_mask[i];
        end
    end

    // Release pulse still high means the old config is on its way out
    assign run_start = merge_config.valid & ~run_active & ~config_release;

    assign group_issue = run_active & (&lane_ready) & ~out_prog_full
                       & (issued_cnt != merge_config.mode.count);

    assign lane_pop = {merge_data_pkg::NUM_LANES{group_issue}} & merge_config.mode.lane_mask;

    assign last_push = result_valid & (pushed_cnt == merge_config.mode.count - 1'b1);

    // ------------------------------------------------
    // Run control and counters
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            run_active     <= 1'b0;
            issued_cnt     <= '0;
            pushed_cnt     <= '0;
            emitted_all    <= 1'b0;
            config_release <= 1'b0;
            group_valid_d1 <= 1'b0;
            result_valid   <= 1'b0;
        end else begin
            config_release <= 1'b0;
            group_valid_d1 <= group_issue;
            result_valid   <= group_valid_d1;
            if (run_start) begin
                // Zero count finishes on the spot
                run_active     <= (merge_config.mode.count != '0);
                emitted_all    <= (merge_config.mode.count == '0);
                config_release <= (merge_config.mode.count == '0);
                issued_cnt     <= '0;
                pushed_cnt     <= '0;
            end else begin
                if (group_issue) begin
                    issued_cnt <= issued_cnt + 1'b1;
                end
                if (result_valid) begin
                    pushed_cnt <= pushed_cnt + 1'b1;
                end
                if (last_push) begin
                    run_active     <= 1'b0;
                    emitted_all    <= 1'b1;
                    config_release <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------
    // Combine stage
    // ------------------------------------------------
    // Lane data is valid the cycle after the group pop
    always_comb begin
        combined = merge_config.bias;
        for (int i = 0; i < merge_data_pkg::NUM_LANES; i++) begin
            if (merge_config.mode.lane_mask[i]) begin
                case (merge_config.mode.op)
                    merge_data_pkg::OP_ADD: begin
                        combined = combined + lane_data[i].data;
                    end
                    merge_data_pkg::OP_MAX: begin
                        if (lane_data[i].data > combined) begin
                            combined = lane_data[i].data;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (group_valid_d1) begin
            result_data <= combined;
        end
    end

    // Address is the sequence number of the merged packet
    assign merged_push         = result_valid;
    assign merged_data.address = pushed_cnt;
    assign merged_data.data    = result_data;

endmodule
